// ==== common/memCtrlPkg.sv ====
package memCtrlPkg;

    // ####################
    // Command encoding
    // ####################

    typedef enum logic [2:0] {
        cmdNone           = 3'd0,
        cmdCopyExtToCache = 3'd1,
        cmdCopyCacheToExt = 3'd2,
        cmdReadSingle     = 3'd3,
        cmdWriteSingle    = 3'd4
    } memCmd;

    // ####################
    // Cache banks
    // ####################

    localparam int numCaches = 2;
    localparam int cacheIdWidth = 1;

    // Word address into one cache SRAM bank
    localparam int sramAddrWidth = 10;

    // ####################
    // External bus
    // ####################

    // Header word 1 holds the write flag in bit 31 above this address
    localparam int extAddrWidth = 30;
    localparam int dataWidth = 32;

    // Header word 2 carries the length in its low bits
    localparam int lenWidth = 8;

    // Fixed length of both copy commands
    localparam int blockWords = 32;

    // ####################
    // Status
    // ####################

    localparam int rqIdWidth = 4;

    // Wide enough to count a full block
    localparam int progressWidth = 6;

endpackage

// ==== source/commandSequencer.sv ====
module commandSequencer (
    input  logic clk,
    input  logic rst,

    input  memCtrlPkg::memCmd cmd,
    input  logic [memCtrlPkg::rqIdWidth-1:0] rqId,
    input  logic [memCtrlPkg::cacheIdWidth-1:0] cacheId,
    input  logic [memCtrlPkg::sramAddrWidth-1:0] sramAddr,
    input  logic [memCtrlPkg::extAddrWidth-1:0] extAddr,
    input  logic [memCtrlPkg::dataWidth-1:0] writeData,

    input  logic memBusy,
    input  logic cacheBusy,
    input  logic advance,
    input  logic [memCtrlPkg::dataWidth-1:0] memData,

    output logic memStart,
    output logic memWrite,
    output logic [memCtrlPkg::lenWidth-1:0] memLen,
    output logic [memCtrlPkg::extAddrWidth-1:0] memAddr,

    output logic cacheStart,
    output logic cacheWrite,
    output logic [memCtrlPkg::lenWidth-1:0] cacheLen,
    output logic [memCtrlPkg::cacheIdWidth-1:0] cacheSel,
    output logic [memCtrlPkg::sramAddrWidth-1:0] cacheAddr,

    output logic [memCtrlPkg::dataWidth-1:0] seqData,
    output logic useSeqData,

    output logic busy,
    output logic [memCtrlPkg::rqIdWidth-1:0] statRqId,
    output logic [memCtrlPkg::progressWidth-1:0] progress,
    output logic [memCtrlPkg::dataWidth-1:0] result,
    output logic resultValid
);

    import memCtrlPkg::*;

    typedef enum logic {
        stIdle,
        stXfer
    } seqState;

    seqState state;
    logic accept;
    logic isCopy;
    logic readCmd;

    // ####################
    // Command decode
    // ####################

    assign accept = (state == stIdle) && (cmd != cmdNone);
    assign isCopy = (cmd == cmdCopyExtToCache) || (cmd == cmdCopyCacheToExt);

    // Both interfaces start in the accept cycle so their busy is up by the next one
    assign memStart = accept;
    assign memWrite = (cmd == cmdCopyCacheToExt) || (cmd == cmdWriteSingle);
    assign memLen = isCopy ? lenWidth'(blockWords) : lenWidth'(1);
    assign memAddr = extAddr;

    assign cacheStart = accept && isCopy;
    assign cacheWrite = (cmd == cmdCopyExtToCache);
    assign cacheLen = lenWidth'(blockWords);
    assign cacheSel = cacheId;
    assign cacheAddr = sramAddr;

    assign busy = (state == stXfer);

    // ####################
    // Control state
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            progress <= '0;
            resultValid <= 1'b0;
            readCmd <= 1'b0;
            useSeqData <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            case (state)
                stIdle: begin
                    if (accept) begin
                        state <= stXfer;
                        progress <= '0;
                        readCmd <= (cmd == cmdReadSingle);
                        useSeqData <= (cmd == cmdWriteSingle);
                    end
                end
                stXfer: begin
                    // Done once neither interface has words left
                    if (!memBusy && !cacheBusy) begin
                        state <= stIdle;
                    end
                    if (advance) begin
                        progress <= progress + 1'b1;
                        resultValid <= readCmd;
                    end
                end
            endcase
        end
    end

    // Tag, write word and read result
    always_ff @(posedge clk) begin
        if (accept) begin
            statRqId <= rqId;
            seqData <= writeData;
        end
        if (busy && advance && readCmd) begin
            result <= memData;
        end
    end

    cmdEncodingValid: assert property (@(posedge clk) disable iff (rst)
        cmd inside {cmdNone, cmdCopyExtToCache, cmdCopyCacheToExt, cmdReadSingle,
                    cmdWriteSingle});

endmodule

// ==== cacheInterface/cacheInterface.sv ====
module cacheInterface (
    input  logic clk,
    input  logic rst,

    input  logic cacheStart,
    input  logic cacheWrite,
    input  logic [memCtrlPkg::lenWidth-1:0] cacheLen,
    input  logic [memCtrlPkg::cacheIdWidth-1:0] cacheSel,
    input  logic [memCtrlPkg::sramAddrWidth-1:0] cacheAddr,
    output logic cacheBusy,

    input  logic advance,
    input  logic [memCtrlPkg::dataWidth-1:0] memData,
    output logic [memCtrlPkg::dataWidth-1:0] wrData,

    output logic cacheCe [memCtrlPkg::numCaches],
    output logic cacheWe [memCtrlPkg::numCaches],
    output logic [memCtrlPkg::sramAddrWidth-1:0] sramAddrOut [memCtrlPkg::numCaches],
    output logic [memCtrlPkg::dataWidth-1:0] cacheWrData [memCtrlPkg::numCaches],
    input  logic [memCtrlPkg::dataWidth-1:0] cacheRdData [memCtrlPkg::numCaches]
);

    import memCtrlPkg::*;

    logic writeMode;
    logic [cacheIdWidth-1:0] selReg;
    logic [sramAddrWidth-1:0] addrReg;
    logic [lenWidth-1:0] issueLeft;
    logic [lenWidth-1:0] wordsLeft;

    // Read-ahead buffer
    logic [dataWidth-1:0] buffer [2];
    logic wrPtr;
    logic rdPtr;
    logic [1:0] bufCount;
    logic rdPending;
    logic [1:0] inFlight;
    logic rdIssue;
    logic pop;

    // Word from the bus waiting for its SRAM write
    logic capture;
    logic wrPending;
    logic [dataWidth-1:0] wrWord;

    logic sramAccess;
    logic [numCaches-1:0] ceLow;

    assign cacheBusy = (wordsLeft != '0);

    // Buffered words plus the read still in the SRAM
    assign inFlight = bufCount + {1'b0, rdPending};
    assign pop = cacheBusy && !writeMode && advance;
    assign rdIssue = (issueLeft != '0) && ((inFlight < 2'd2) || pop);
    assign wrData = buffer[rdPtr];

    assign capture = cacheBusy && writeMode && advance;
    assign sramAccess = rdIssue || wrPending;

    // ####################
    // Bank steering
    // ####################

    always_comb begin
        for (int i = 0; i < numCaches; i++) begin
            ceLow[i] = sramAccess && (selReg == cacheIdWidth'(i));
            cacheCe[i] = !ceLow[i];
            cacheWe[i] = !(ceLow[i] && wrPending);
            sramAddrOut[i] = addrReg;
            cacheWrData[i] = wrWord;
        end
    end

    // ####################
    // Control state
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            writeMode <= 1'b0;
            issueLeft <= '0;
            wordsLeft <= '0;
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            bufCount <= '0;
            rdPending <= 1'b0;
            wrPending <= 1'b0;
        end else begin
            rdPending <= rdIssue;
            wrPending <= capture;
            if (cacheStart) begin
                writeMode <= cacheWrite;
                issueLeft <= cacheWrite ? '0 : cacheLen;
                wordsLeft <= cacheLen;
                wrPtr <= 1'b0;
                rdPtr <= 1'b0;
                bufCount <= '0;
            end else begin
                if (rdIssue) begin
                    issueLeft <= issueLeft - 1'b1;
                end
                // Last word is the final pop or the final SRAM write
                if (pop || wrPending) begin
                    wordsLeft <= wordsLeft - 1'b1;
                end
                if (rdPending) begin
                    wrPtr <= !wrPtr;
                end
                if (pop) begin
                    rdPtr <= !rdPtr;
                end
                bufCount <= bufCount + {1'b0, rdPending} - {1'b0, pop};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cacheStart) begin
            selReg <= cacheSel;
            addrReg <= cacheAddr;
        end else if (sramAccess) begin
            addrReg <= addrReg + 1'b1;
        end
        // SRAM data is valid one cycle after the read
        if (rdPending) begin
            buffer[wrPtr] <= cacheRdData[selReg];
        end
        if (capture) begin
            wrWord <= memData;
        end
    end

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        pop |-> (bufCount != 2'd0));

    // A bank is only touched while words of the block are left
    bankEnableWhileBusy: assert property (@(posedge clk) disable iff (rst)
        (ceLow != '0) |-> cacheBusy);

endmodule

// ==== memoryInterface/memoryInterface.sv ====
module memoryInterface (
    input  logic clk,
    input  logic rst,

    input  logic memStart,
    input  logic memWrite,
    input  logic [memCtrlPkg::lenWidth-1:0] memLen,
    input  logic [memCtrlPkg::extAddrWidth-1:0] memAddr,
    output logic memBusy,

    output logic advance,
    input  logic [memCtrlPkg::dataWidth-1:0] wrData,
    output logic [memCtrlPkg::dataWidth-1:0] memData,

    output logic extEn,
    output logic extOen,
    output logic [memCtrlPkg::dataWidth-1:0] extBusOut,
    input  logic extStall,
    input  logic [memCtrlPkg::dataWidth-1:0] extBusIn
);

    import memCtrlPkg::*;

    typedef enum logic [1:0] {
        phIdle,
        phHeader,
        phData
    } busPhase;

    busPhase phase;
    logic secondHeader;
    logic isWrite;
    logic [extAddrWidth-1:0] addrReg;
    logic [lenWidth-1:0] remaining;

    assign memBusy = (phase != phIdle);
    assign extEn = memBusy;

    // Bus is driven for both header words and for write data
    assign extOen = (phase == phHeader) || ((phase == phData) && isWrite);

    // A data word moves in every unstalled data cycle
    assign advance = (phase == phData) && !extStall;
    assign memData = extBusIn;

    // ####################
    // Bus word select
    // ####################

    always_comb begin
        if ((phase == phHeader) && !secondHeader) begin
            extBusOut = {isWrite, 1'b0, addrReg};
        end else if (phase == phHeader) begin
            extBusOut = {{(dataWidth - lenWidth){1'b0}}, remaining};
        end else begin
            extBusOut = wrData;
        end
    end

    // ####################
    // Phase sequencing
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phIdle;
            secondHeader <= 1'b0;
            remaining <= '0;
        end else begin
            case (phase)
                phIdle: begin
                    if (memStart) begin
                        phase <= phHeader;
                        secondHeader <= 1'b0;
                        remaining <= memLen;
                    end
                end
                phHeader: begin
                    if (!extStall) begin
                        secondHeader <= 1'b1;
                        if (secondHeader) begin
                            phase <= phData;
                        end
                    end
                end
                phData: begin
                    if (advance) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == lenWidth'(1)) begin
                            phase <= phIdle;
                        end
                    end
                end
                default: begin
                    phase <= phIdle;
                end
            endcase
        end
    end

    // Header fields held for the whole transaction
    always_ff @(posedge clk) begin
        if (memStart) begin
            isWrite <= memWrite;
            addrReg <= memAddr;
        end
    end

    noStartWhileBusy: assert property (@(posedge clk) disable iff (rst)
        memStart |-> !memBusy);

endmodule

// ==== source/memoryController.sv ====
module memoryController (
    input  logic clk,
    input  logic rst,

    input  memCtrlPkg::memCmd cmd,
    input  logic [memCtrlPkg::rqIdWidth-1:0] rqId,
    input  logic [memCtrlPkg::cacheIdWidth-1:0] cacheId,
    input  logic [memCtrlPkg::sramAddrWidth-1:0] sramAddr,
    input  logic [memCtrlPkg::extAddrWidth-1:0] extAddr,
    input  logic [memCtrlPkg::dataWidth-1:0] writeData,

    output logic busy,
    output logic [memCtrlPkg::rqIdWidth-1:0] statRqId,
    output logic [memCtrlPkg::progressWidth-1:0] progress,
    output logic [memCtrlPkg::dataWidth-1:0] result,
    output logic resultValid,

    output logic cacheCe [memCtrlPkg::numCaches],
    output logic cacheWe [memCtrlPkg::numCaches],
    output logic [memCtrlPkg::sramAddrWidth-1:0] cacheAddr [memCtrlPkg::numCaches],
    output logic [memCtrlPkg::dataWidth-1:0] cacheWrData [memCtrlPkg::numCaches],
    input  logic [memCtrlPkg::dataWidth-1:0] cacheRdData [memCtrlPkg::numCaches],

    output logic extEn,
    output logic extOen,
    output logic [memCtrlPkg::dataWidth-1:0] extBusOut,
    input  logic extStall,
    input  logic [memCtrlPkg::dataWidth-1:0] extBusIn
);

    import memCtrlPkg::*;

    logic memStart;
    logic memWrite;
    logic [lenWidth-1:0] memLen;
    logic [extAddrWidth-1:0] memAddr;
    logic memBusy;

    logic cacheStart;
    logic cacheWrite;
    logic [lenWidth-1:0] cacheLen;
    logic [cacheIdWidth-1:0] cacheSel;
    logic [sramAddrWidth-1:0] cacheStartAddr;
    logic cacheBusy;

    logic advance;
    logic [dataWidth-1:0] memData;
    logic [dataWidth-1:0] seqData;
    logic useSeqData;
    logic [dataWidth-1:0] cacheOutData;
    logic [dataWidth-1:0] wrData;

    // Single writes take their word from the sequencer, copies from the buffer
    assign wrData = useSeqData ? seqData : cacheOutData;

    commandSequencer sequencer_i (
        .clk(clk),
        .rst(rst),
        .cmd(cmd),
        .rqId(rqId),
        .cacheId(cacheId),
        .sramAddr(sramAddr),
        .extAddr(extAddr),
        .writeData(writeData),
        .memBusy(memBusy),
        .cacheBusy(cacheBusy),
        .advance(advance),
        .memData(memData),
        .memStart(memStart),
        .memWrite(memWrite),
        .memLen(memLen),
        .memAddr(memAddr),
        .cacheStart(cacheStart),
        .cacheWrite(cacheWrite),
        .cacheLen(cacheLen),
        .cacheSel(cacheSel),
        .cacheAddr(cacheStartAddr),
        .seqData(seqData),
        .useSeqData(useSeqData),
        .busy(busy),
        .statRqId(statRqId),
        .progress(progress),
        .result(result),
        .resultValid(resultValid)
    );

    cacheInterface cacheIf_i (
        .clk(clk),
        .rst(rst),
        .cacheStart(cacheStart),
        .cacheWrite(cacheWrite),
        .cacheLen(cacheLen),
        .cacheSel(cacheSel),
        .cacheAddr(cacheStartAddr),
        .cacheBusy(cacheBusy),
        .advance(advance),
        .memData(memData),
        .wrData(cacheOutData),
        .cacheCe(cacheCe),
        .cacheWe(cacheWe),
        .sramAddrOut(cacheAddr),
        .cacheWrData(cacheWrData),
        .cacheRdData(cacheRdData)
    );

    memoryInterface memIf_i (
        .clk(clk),
        .rst(rst),
        .memStart(memStart),
        .memWrite(memWrite),
        .memLen(memLen),
        .memAddr(memAddr),
        .memBusy(memBusy),
        .advance(advance),
        .wrData(wrData),
        .memData(memData),
        .extEn(extEn),
        .extOen(extOen),
        .extBusOut(extBusOut),
        .extStall(extStall),
        .extBusIn(extBusIn)
    );

endmodule

// ==== test/memoryControllerTb.sv ====
module memoryControllerTb;

    import memCtrlPkg::*;

    localparam int numVectors = 14;
    localparam int vecCols = 7;
    localparam int memWords = 1024;

    logic clk;
    logic rst;
    memCmd cmd;
    logic [rqIdWidth-1:0] rqId;
    logic [cacheIdWidth-1:0] cacheId;
    logic [sramAddrWidth-1:0] sramAddr;
    logic [extAddrWidth-1:0] extAddr;
    logic [dataWidth-1:0] writeData;
    logic busy;
    logic [rqIdWidth-1:0] statRqId;
    logic [progressWidth-1:0] progress;
    logic [dataWidth-1:0] result;
    logic resultValid;
    logic cacheCe [numCaches];
    logic cacheWe [numCaches];
    logic [sramAddrWidth-1:0] cacheAddr [numCaches];
    logic [dataWidth-1:0] cacheWrData [numCaches];
    logic [dataWidth-1:0] cacheRdData [numCaches];
    logic extEn;
    logic extOen;
    logic [dataWidth-1:0] extBusOut;
    logic extStall;
    logic [dataWidth-1:0] extBusIn;

    logic [31:0] vecWords [numVectors * vecCols];
    logic [31:0] extMem [memWords];
    logic [31:0] refExt [memWords];
    logic [31:0] bankMem [numCaches][memWords];
    logic [31:0] refBank [numCaches][memWords];

    // External bus model state
    logic [1:0] wordCount;
    logic hdrWrite;
    logic [9:0] dataPtr;
    logic [31:0] hdrWord1;
    logic [31:0] hdrWord2;

    int unsigned lcgState;
    int pulseCount;
    logic [31:0] lastResult;
    int idx;

    memoryController dut_i (
        .clk(clk),
        .rst(rst),
        .cmd(cmd),
        .rqId(rqId),
        .cacheId(cacheId),
        .sramAddr(sramAddr),
        .extAddr(extAddr),
        .writeData(writeData),
        .busy(busy),
        .statRqId(statRqId),
        .progress(progress),
        .result(result),
        .resultValid(resultValid),
        .cacheCe(cacheCe),
        .cacheWe(cacheWe),
        .cacheAddr(cacheAddr),
        .cacheWrData(cacheWrData),
        .cacheRdData(cacheRdData),
        .extEn(extEn),
        .extOen(extOen),
        .extBusOut(extBusOut),
        .extStall(extStall),
        .extBusIn(extBusIn)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] extFill(input logic [9:0] a);
        return {6'b100000, a, 6'b000000, a};
    endfunction

    function automatic logic [31:0] bankFill(input int b, input logic [9:0] a);
        return {2'b11, b[0], 3'b000, a, 6'b000000, a};
    endfunction

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic abortRun();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            abortRun();
        end
    endtask

    // ####################
    // Memory models
    // ####################

    // Stall is high about one cycle in three
    always @(negedge clk) begin
        extStall <= ((nextRand() >> 16) % 3) == 0;
    end

    always @(posedge clk) begin
        for (int b = 0; b < numCaches; b++) begin
            if (!cacheCe[b]) begin
                if (!cacheWe[b]) begin
                    bankMem[b][cacheAddr[b]] <= cacheWrData[b];
                end else begin
                    cacheRdData[b] <= bankMem[b][cacheAddr[b]];
                end
            end
        end
    end

    assign extBusIn = extMem[dataPtr];

    // Two header words, then data words until extEn drops
    always @(posedge clk) begin
        if (rst || !extEn) begin
            wordCount <= 2'd0;
        end else if (!extStall) begin
            if (wordCount == 2'd0) begin
                checkValue("extOen", extOen, 1);
                hdrWord1 <= extBusOut;
                hdrWrite <= extBusOut[31];
                dataPtr <= extBusOut[9:0];
                wordCount <= 2'd1;
            end else if (wordCount == 2'd1) begin
                checkValue("extOen", extOen, 1);
                hdrWord2 <= extBusOut;
                wordCount <= 2'd2;
            end else begin
                checkValue("extOen", extOen, hdrWrite);
                if (hdrWrite) begin
                    extMem[dataPtr] <= extBusOut;
                end
                dataPtr <= dataPtr + 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && resultValid === 1'b1) begin
            pulseCount++;
            lastResult = result;
        end
    end

    // ####################
    // Sequencing
    // ####################

    task automatic waitBusyLow(input int limit);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0) begin
            if (cycles == limit) begin
                $display("Timeout: busy did not fall within %0d cycles", limit);
                abortRun();
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic compareMemories();
        for (int a = 0; a < memWords; a++) begin
            checkValue($sformatf("extMem[%0h]", a), extMem[a], refExt[a]);
            for (int b = 0; b < numCaches; b++) begin
                checkValue($sformatf("bankMem%0d[%0h]", b, a), bankMem[b][a], refBank[b][a]);
            end
        end
    endtask

    task automatic applyVector(input int base);
        cmd = memCmd'(vecWords[base][2:0]);
        rqId = vecWords[base + 1][rqIdWidth-1:0];
        cacheId = vecWords[base + 2][cacheIdWidth-1:0];
        sramAddr = vecWords[base + 3][sramAddrWidth-1:0];
        extAddr = vecWords[base + 4][extAddrWidth-1:0];
        writeData = vecWords[base + 5];
    endtask

    task automatic runVector(input int v, input logic withDrop);
        int base;
        memCmd op;
        int bank;
        logic [9:0] sram;
        logic [9:0] ext;
        logic [31:0] expected;
        logic isWrite;
        int len;
        logic [9:0] sIdx;
        logic [9:0] eIdx;
        base = v * vecCols;
        op = memCmd'(vecWords[base][2:0]);
        bank = vecWords[base + 2][0];
        sram = vecWords[base + 3][9:0];
        ext = vecWords[base + 4][9:0];
        expected = vecWords[base + 6];
        isWrite = (op == cmdCopyCacheToExt) || (op == cmdWriteSingle);
        len = ((op == cmdCopyExtToCache) || (op == cmdCopyCacheToExt)) ? blockWords : 1;
        pulseCount = 0;
        applyVector(base);
        @(negedge clk);
        checkValue("busy", busy, 1);
        // Second command lands while the first one is running
        if (withDrop) begin
            applyVector(base + vecCols);
            @(negedge clk);
        end
        cmd = cmdNone;
        waitBusyLow(400);

        for (int i = 0; i < len; i++) begin
            sIdx = sram + i[9:0];
            eIdx = ext + i[9:0];
            case (op)
                cmdWriteSingle: refExt[ext] = vecWords[base + 5];
                cmdCopyExtToCache: refBank[bank][sIdx] = refExt[eIdx];
                cmdCopyCacheToExt: refExt[eIdx] = refBank[bank][sIdx];
                default: ;
            endcase
        end

        checkValue("statRqId", statRqId, vecWords[base + 1]);
        checkValue("progress", progress, len);
        checkValue("resultValid pulses", pulseCount, (op == cmdReadSingle) ? 1 : 0);
        checkValue("header word 1", hdrWord1, {isWrite, 1'b0, vecWords[base + 4][29:0]});
        checkValue("header word 2", hdrWord2, len);
        case (op)
            cmdReadSingle: begin
                checkValue("result", lastResult, expected);
                checkValue("result", lastResult, refExt[ext]);
            end
            cmdCopyExtToCache: checkValue("bankMem", bankMem[bank][sram], expected);
            default: checkValue("extMem", extMem[ext], expected);
        endcase
        compareMemories();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cmd = cmdNone;
        rqId = '0;
        cacheId = '0;
        sramAddr = '0;
        extAddr = '0;
        writeData = '0;
        extStall = 1'b0;
        cacheRdData[0] = '0;
        cacheRdData[1] = '0;
        dataPtr = '0;
        lcgState = 73;
        pulseCount = 0;
        lastResult = '0;
        for (int a = 0; a < memWords; a++) begin
            extMem[a] = extFill(a[9:0]);
            refExt[a] = extFill(a[9:0]);
            for (int b = 0; b < numCaches; b++) begin
                bankMem[b][a] = bankFill(b, a[9:0]);
                refBank[b][a] = bankFill(b, a[9:0]);
            end
        end
        $readmemh("test/memCtrl_vectors.txt", vecWords);

        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkValue("busy", busy, 0);
        checkValue("extEn", extEn, 0);
        checkValue("extOen", extOen, 0);
        checkValue("resultValid", resultValid, 0);
        checkValue("progress", progress, 0);
        for (int b = 0; b < numCaches; b++) begin
            checkValue($sformatf("cacheCe[%0d]", b), cacheCe[b], 1);
            checkValue($sformatf("cacheWe[%0d]", b), cacheWe[b], 1);
        end

        idx = 0;
        while (idx < numVectors) begin
            if ((idx + 1 < numVectors) && vecWords[(idx + 1) * vecCols][7]) begin
                runVector(idx, 1'b1);
                idx += 2;
            end else begin
                runVector(idx, 1'b0);
                idx += 1;
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== test/memCtrl_vectors.txt ====
// cmd tag bank sramAddr extAddr writeWord expectedWord, all hex, one command per line
// cmd with bit 7 set is sent while the command above is still busy and must be dropped
03 1 0 000 0100 00000000 81000100
03 2 0 000 03FF 00000000 83FF03FF
04 3 0 000 0200 DEADBEEF DEADBEEF
03 4 0 000 0200 00000000 DEADBEEF
01 5 1 040 0300 00000000 83000300
02 6 0 080 0080 00000000 C0800080
01 7 0 100 0200 00000000 DEADBEEF
84 8 0 000 0210 12345678 00000000
02 9 1 040 0380 00000000 83000300
83 A 0 000 0100 00000000 00000000
04 B 1 000 03E0 0BADF00D 0BADF00D
01 C 1 3E0 03E0 00000000 0BADF00D
03 D 0 000 0390 00000000 83100310
02 E 1 3F0 0000 00000000 83F003F0

// ==== list.f ====
common/memCtrlPkg.sv
source/commandSequencer.sv
cacheInterface/cacheInterface.sv
memoryInterface/memoryInterface.sv
source/memoryController.sv
test/memoryControllerTb.sv
